/* hdl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    localparam int instr_w = 32;

    // Base opcode map, bits 6:0 of the instruction word
    typedef enum logic [6:0] {
        LOAD      = 7'b00_000_11,
        LOAD_FP   = 7'b00_001_11,
        custom_0  = 7'b00_010_11,
        MISC_MEM  = 7'b00_011_11,
        OP_IMM    = 7'b00_100_11,
        AUIPC     = 7'b00_101_11,
        OP_IMM_32 = 7'b00_110_11,

        STORE     = 7'b01_000_11,
        STORE_FP  = 7'b01_001_11,
        custom_1  = 7'b01_010_11,
        AMO       = 7'b01_011_11,
        OP        = 7'b01_100_11,
        LUI       = 7'b01_101_11,
        OP_32     = 7'b01_110_11,

        MADD      = 7'b10_000_11,
        MSUB      = 7'b10_001_11,
        NMSUB     = 7'b10_010_11,
        NMADD     = 7'b10_011_11,
        OP_FP     = 7'b10_100_11,
        custom_2  = 7'b10_110_11,

        BRANCH    = 7'b11_000_11,
        JALR      = 7'b11_001_11,
        JAL       = 7'b11_011_11,
        SYSTEM    = 7'b11_100_11,
        custom_3  = 7'b11_110_11
    } opcode_e;

    typedef enum logic [2:0] {
        R    = 3'd0,
        I    = 3'd1,
        S    = 3'd2,
        B    = 3'd3,
        U    = 3'd4,
        J    = 3'd5,
        NONE = 3'd7  // Unknown opcode
    } instr_format_e;

    // funct3 of the Zicsr instructions under SYSTEM
    typedef enum logic [2:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_funct3_e;

endpackage

/* hdl/decode_uarch_pkg.sv */
package decode_uarch_pkg;

    // Immediate as assembled from the word, before extension to xlen
    localparam int imm_base_w = 32;

    localparam int reg_index_w = 5;   // x0 to x31
    localparam int csr_index_w = 12;  // Full CSR address space

    typedef enum logic {
        OK      = 1'b0,
        ILLEGAL = 1'b1
    } decode_status_e;

endpackage

/* hdl/instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder (
    input  logic [riscv_isa_pkg::instr_w-1:0]         instr,
    output riscv_isa_pkg::opcode_e                    opcode,
    output riscv_isa_pkg::instr_format_e              format,
    output logic [2:0]                                funct3,
    output logic [6:0]                                funct7,
    output logic [11:0]                               funct12,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  rs1,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  rs2,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  rd,
    output logic [decode_uarch_pkg::csr_index_w-1:0]  csr_index,
    output logic                                      rs1_en,
    output logic                                      rs2_en,
    output logic                                      rd_en,
    output logic                                      csr_rd_en,
    output logic                                      csr_wr_en,
    output decode_uarch_pkg::decode_status_e          status
);

    logic rd_sel;
    logic is_csr;

    assign opcode    = riscv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign funct12   = instr[31:20];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign rd        = instr[11:7];
    assign csr_index = instr[31:20];

    always_comb begin
        case (opcode)
            riscv_isa_pkg::OP,
            riscv_isa_pkg::OP_32,
            riscv_isa_pkg::OP_FP,
            riscv_isa_pkg::AMO,
            riscv_isa_pkg::MADD,
            riscv_isa_pkg::MSUB,
            riscv_isa_pkg::NMSUB,
            riscv_isa_pkg::NMADD:     format = riscv_isa_pkg::R;  // R4 forms use R fields
            riscv_isa_pkg::LOAD,
            riscv_isa_pkg::LOAD_FP,
            riscv_isa_pkg::MISC_MEM,
            riscv_isa_pkg::OP_IMM,
            riscv_isa_pkg::OP_IMM_32,
            riscv_isa_pkg::JALR,
            riscv_isa_pkg::SYSTEM:    format = riscv_isa_pkg::I;
            riscv_isa_pkg::STORE,
            riscv_isa_pkg::STORE_FP:  format = riscv_isa_pkg::S;
            riscv_isa_pkg::BRANCH:    format = riscv_isa_pkg::B;
            riscv_isa_pkg::AUIPC,
            riscv_isa_pkg::LUI:       format = riscv_isa_pkg::U;
            riscv_isa_pkg::JAL:       format = riscv_isa_pkg::J;
            default:                  format = riscv_isa_pkg::NONE;
        endcase
    end

    always_comb begin
        rs1_en = 1'b0;
        rs2_en = 1'b0;
        rd_sel = 1'b0;
        case (format)
            riscv_isa_pkg::R: begin
                rs1_en = 1'b1;
                rs2_en = 1'b1;
                rd_sel = 1'b1;
            end
            riscv_isa_pkg::I: begin
                rs1_en = 1'b1;
                rd_sel = 1'b1;
            end
            riscv_isa_pkg::S,
            riscv_isa_pkg::B: begin
                rs1_en = 1'b1;
                rs2_en = 1'b1;
            end
            riscv_isa_pkg::U,
            riscv_isa_pkg::J: begin
                rd_sel = 1'b1;
            end
            default: begin
                rs1_en = 1'b0;  // Illegal, nothing enabled
            end
        endcase
    end

    // ECALL, EBREAK and friends share SYSTEM but touch no CSR
    always_comb begin
        is_csr = 1'b0;
        if (opcode == riscv_isa_pkg::SYSTEM) begin
            case (riscv_isa_pkg::csr_funct3_e'(funct3))
                riscv_isa_pkg::CSRRW,
                riscv_isa_pkg::CSRRS,
                riscv_isa_pkg::CSRRC,
                riscv_isa_pkg::CSRRWI,
                riscv_isa_pkg::CSRRSI,
                riscv_isa_pkg::CSRRCI: is_csr = 1'b1;
                default:               is_csr = 1'b0;
            endcase
        end
    end

    assign rd_en     = rd_sel && (rd != '0);  // Writes to x0 dropped
    assign csr_rd_en = is_csr;
    assign csr_wr_en = is_csr;

    assign status = (format == riscv_isa_pkg::NONE) ? decode_uarch_pkg::ILLEGAL
                                                    : decode_uarch_pkg::OK;

endmodule

/* hdl/immediate_generator.sv */
`timescale 1ns/1ps

module immediate_generator #(
    parameter int xlen = 32
) (
    input  logic [riscv_isa_pkg::instr_w-1:0] instr,
    input  riscv_isa_pkg::instr_format_e      format,
    output logic [xlen-1:0]                   imm
);

    logic [decode_uarch_pkg::imm_base_w-1:0] imm_base;

    always_comb begin
        case (format)
            riscv_isa_pkg::I: begin
                imm_base = {{20{instr[31]}}, instr[31:20]};
            end
            riscv_isa_pkg::S: begin
                imm_base = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            riscv_isa_pkg::B: begin
                imm_base = {{19{instr[31]}}, instr[31], instr[7],
                            instr[30:25], instr[11:8], 1'b0};  // Halfword offset
            end
            riscv_isa_pkg::U: begin
                imm_base = {instr[31:12], 12'b0};
            end
            riscv_isa_pkg::J: begin
                imm_base = {{11{instr[31]}}, instr[31], instr[19:12],
                            instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm_base = '0;  // R and NONE
            end
        endcase
    end

    // On RV64 every form sign-extends from bit 31, U included
    always_comb begin
        imm = {xlen{imm_base[decode_uarch_pkg::imm_base_w-1]}};
        imm[decode_uarch_pkg::imm_base_w-1:0] = imm_base;
    end

endmodule

/* hdl/decode_issue_queue.sv */
`timescale 1ns/1ps

module decode_issue_queue #(
    parameter int xlen            = 32,
    parameter int queue_depth     = 4,
    parameter int out_credit_init = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      in_valid,
    input  riscv_isa_pkg::opcode_e                    opcode,
    input  riscv_isa_pkg::instr_format_e              format,
    input  logic [2:0]                                funct3,
    input  logic [6:0]                                funct7,
    input  logic [11:0]                               funct12,
    input  logic [decode_uarch_pkg::reg_index_w-1:0]  rs1,
    input  logic [decode_uarch_pkg::reg_index_w-1:0]  rs2,
    input  logic [decode_uarch_pkg::reg_index_w-1:0]  rd,
    input  logic [decode_uarch_pkg::csr_index_w-1:0]  csr_index,
    input  logic                                      rs1_en,
    input  logic                                      rs2_en,
    input  logic                                      rd_en,
    input  logic                                      csr_rd_en,
    input  logic                                      csr_wr_en,
    input  decode_uarch_pkg::decode_status_e          status,
    input  logic [xlen-1:0]                           imm,
    output logic                                      in_credit,
    output logic                                      out_valid,
    output riscv_isa_pkg::opcode_e                    out_opcode,
    output riscv_isa_pkg::instr_format_e              out_format,
    output logic [2:0]                                out_funct3,
    output logic [6:0]                                out_funct7,
    output logic [11:0]                               out_funct12,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  out_rs1,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  out_rs2,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  out_rd,
    output logic [decode_uarch_pkg::csr_index_w-1:0]  out_csr_index,
    output logic                                      out_rs1_en,
    output logic                                      out_rs2_en,
    output logic                                      out_rd_en,
    output logic                                      out_csr_rd_en,
    output logic                                      out_csr_wr_en,
    output decode_uarch_pkg::decode_status_e          out_status,
    output logic [xlen-1:0]                           out_imm,
    input  logic                                      out_credit
);

    localparam int entry_w = $bits(opcode) + $bits(format) + $bits(funct3) + $bits(funct7)
                           + $bits(funct12) + 3 * decode_uarch_pkg::reg_index_w
                           + decode_uarch_pkg::csr_index_w + 5 + $bits(status) + xlen;
    localparam int ptr_w    = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w    = $clog2(queue_depth + 1);
    localparam int credit_w = (out_credit_init > 0) ? $clog2(out_credit_init + 1) : 1;

    logic [entry_w-1:0]  mem [queue_depth];
    logic [entry_w-1:0]  wr_entry;
    logic [entry_w-1:0]  rd_entry;
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;
    logic [credit_w-1:0] credit_cnt;
    logic                push;
    logic                pop;
    logic [6:0]          head_opcode;
    logic [2:0]          head_format;
    logic                head_status;

    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Fetch never sends without a credit, so no full check here
    assign push = in_valid;
    assign pop  = out_valid;

    assign out_valid = (count != '0) && (credit_cnt != '0);

    assign wr_entry = {opcode, format, funct3, funct7, funct12, rs1, rs2, rd, csr_index,
                       rs1_en, rs2_en, rd_en, csr_rd_en, csr_wr_en, status, imm};

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    assign rd_entry = mem[rd_ptr];
    assign {head_opcode, head_format, out_funct3, out_funct7, out_funct12, out_rs1, out_rs2,
            out_rd, out_csr_index, out_rs1_en, out_rs2_en, out_rd_en, out_csr_rd_en,
            out_csr_wr_en, head_status, out_imm} = rd_entry;

    assign out_opcode = riscv_isa_pkg::opcode_e'(head_opcode);
    assign out_format = riscv_isa_pkg::instr_format_e'(head_format);
    assign out_status = decode_uarch_pkg::decode_status_e'(head_status);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Credits from execute, spent one per departure
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= credit_w'(out_credit_init);
        end else begin
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;  // Slot freed, one credit back to fetch
        end
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
    parameter int xlen            = 32,
    parameter int queue_depth     = 4,
    parameter int out_credit_init = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      in_valid,
    input  logic [riscv_isa_pkg::instr_w-1:0]         in_instr,
    output logic                                      in_credit,
    input  logic                                      out_credit,
    output logic                                      out_valid,
    output riscv_isa_pkg::opcode_e                    out_opcode,
    output riscv_isa_pkg::instr_format_e              out_format,
    output logic [2:0]                                out_funct3,
    output logic [6:0]                                out_funct7,
    output logic [11:0]                               out_funct12,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  out_rs1,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  out_rs2,
    output logic [decode_uarch_pkg::reg_index_w-1:0]  out_rd,
    output logic [decode_uarch_pkg::csr_index_w-1:0]  out_csr_index,
    output logic                                      out_rs1_en,
    output logic                                      out_rs2_en,
    output logic                                      out_rd_en,
    output logic                                      out_csr_rd_en,
    output logic                                      out_csr_wr_en,
    output decode_uarch_pkg::decode_status_e          out_status,
    output logic [xlen-1:0]                           out_imm
);

    riscv_isa_pkg::opcode_e                   opcode;
    riscv_isa_pkg::instr_format_e             format;
    logic [2:0]                               funct3;
    logic [6:0]                               funct7;
    logic [11:0]                              funct12;
    logic [decode_uarch_pkg::reg_index_w-1:0] rs1;
    logic [decode_uarch_pkg::reg_index_w-1:0] rs2;
    logic [decode_uarch_pkg::reg_index_w-1:0] rd;
    logic [decode_uarch_pkg::csr_index_w-1:0] csr_index;
    logic                                     rs1_en;
    logic                                     rs2_en;
    logic                                     rd_en;
    logic                                     csr_rd_en;
    logic                                     csr_wr_en;
    decode_uarch_pkg::decode_status_e         status;
    logic [xlen-1:0]                          imm;

    instruction_decoder decoder_i (
        .instr (in_instr),
        .opcode, .format, .funct3, .funct7, .funct12,
        .rs1, .rs2, .rd, .csr_index,
        .rs1_en, .rs2_en, .rd_en, .csr_rd_en, .csr_wr_en,
        .status
    );

    // Format comes from the decoder in the same cycle
    immediate_generator #(
        .xlen (xlen)
    ) imm_gen_i (
        .instr  (in_instr),
        .format (format),
        .imm    (imm)
    );

    decode_issue_queue #(
        .xlen            (xlen),
        .queue_depth     (queue_depth),
        .out_credit_init (out_credit_init)
    ) queue_i (
        .clk, .rst_n, .in_valid,
        .opcode, .format, .funct3, .funct7, .funct12,
        .rs1, .rs2, .rd, .csr_index,
        .rs1_en, .rs2_en, .rd_en, .csr_rd_en, .csr_wr_en,
        .status, .imm,
        .in_credit, .out_valid,
        .out_opcode, .out_format, .out_funct3, .out_funct7, .out_funct12,
        .out_rs1, .out_rs2, .out_rd, .out_csr_index,
        .out_rs1_en, .out_rs2_en, .out_rd_en, .out_csr_rd_en, .out_csr_wr_en,
        .out_status, .out_imm,
        .out_credit
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;  // Released just after an edge
    end

endmodule

/* verification/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int xlen            = 32;
    localparam int queue_depth     = 4;
    localparam int out_credit_init = 2;
    localparam int max_cycles      = 3000;
    localparam int stall_after     = 10;  // Credits given before the long stall
    localparam int stall_cycles    = 40;

    typedef struct packed {
        logic [31:0] instr;
        logic [2:0]  format;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] csr;
        logic        rs1_en;
        logic        rs2_en;
        logic        rd_en;
        logic        csr_en;
        logic [31:0] imm;
        logic        status;
    } expected_t;

    logic                             clk;
    logic                             rst_n;
    logic                             in_valid;
    logic [31:0]                      in_instr;
    logic                             in_credit;
    logic                             out_credit;
    logic                             out_valid;
    riscv_isa_pkg::opcode_e           out_opcode;
    riscv_isa_pkg::instr_format_e     out_format;
    logic [2:0]                       out_funct3;
    logic [6:0]                       out_funct7;
    logic [11:0]                      out_funct12;
    logic [4:0]                       out_rs1;
    logic [4:0]                       out_rs2;
    logic [4:0]                       out_rd;
    logic [11:0]                      out_csr_index;
    logic                             out_rs1_en;
    logic                             out_rs2_en;
    logic                             out_rd_en;
    logic                             out_csr_rd_en;
    logic                             out_csr_wr_en;
    decode_uarch_pkg::decode_status_e out_status;
    logic [xlen-1:0]                  out_imm;

    expected_t exp_q[$];
    integer    seed;
    int        errors;
    int        checks;
    int        sent;
    int        departures;
    int        returned;       // in_credit pulses seen by fetch
    int        credits_given;
    int        credits_taken;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_stage #(
        .xlen            (xlen),
        .queue_depth     (queue_depth),
        .out_credit_init (out_credit_init)
    ) dut_i (
        .clk, .rst_n, .in_valid, .in_instr, .in_credit, .out_credit, .out_valid,
        .out_opcode, .out_format, .out_funct3, .out_funct7, .out_funct12,
        .out_rs1, .out_rs2, .out_rd, .out_csr_index,
        .out_rs1_en, .out_rs2_en, .out_rd_en, .out_csr_rd_en, .out_csr_wr_en,
        .out_status, .out_imm
    );

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp, input int idx);
        checks++;
        assert (got === exp) else begin
            if (idx >= 0) begin
                $display("FAILED %s: got %h, expected %h, entry %0d", name, got, exp, idx);
            end else begin
                $display("FAILED %s: got %h, expected %h", name, got, exp);
            end
            errors++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [31:0] col [14];
        expected_t   e;
        fd = $fopen("verification/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                               col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
                if (code != 14) begin
                    $display("Malformed line in the stimulus file: %s", line);
                    errors++;
                end else begin
                    e.instr  = col[0];
                    e.format = col[1][2:0];
                    e.funct3 = col[2][2:0];
                    e.funct7 = col[3][6:0];
                    e.rs1    = col[4][4:0];
                    e.rs2    = col[5][4:0];
                    e.rd     = col[6][4:0];
                    e.csr    = col[7][11:0];
                    e.rs1_en = col[8][0];
                    e.rs2_en = col[9][0];
                    e.rd_en  = col[10][0];
                    e.csr_en = col[11][0];
                    e.imm    = col[12];
                    e.status = col[13][0];
                    exp_q.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_entry(input expected_t e, input int idx);
        compare_field("out_opcode", 64'(out_opcode), 64'(e.instr[6:0]), idx);
        compare_field("out_format", 64'(out_format), 64'(e.format), idx);
        compare_field("out_funct3", 64'(out_funct3), 64'(e.funct3), idx);
        compare_field("out_funct7", 64'(out_funct7), 64'(e.funct7), idx);
        compare_field("out_funct12", 64'(out_funct12), 64'({e.funct7, e.rs2}), idx);
        compare_field("out_rs1", 64'(out_rs1), 64'(e.rs1), idx);
        compare_field("out_rs2", 64'(out_rs2), 64'(e.rs2), idx);
        compare_field("out_rd", 64'(out_rd), 64'(e.rd), idx);
        compare_field("out_csr_index", 64'(out_csr_index), 64'(e.csr), idx);
        compare_field("out_rs1_en", 64'(out_rs1_en), 64'(e.rs1_en), idx);
        compare_field("out_rs2_en", 64'(out_rs2_en), 64'(e.rs2_en), idx);
        compare_field("out_rd_en", 64'(out_rd_en), 64'(e.rd_en), idx);
        compare_field("out_csr_rd_en", 64'(out_csr_rd_en), 64'(e.csr_en), idx);
        compare_field("out_csr_wr_en", 64'(out_csr_wr_en), 64'(e.csr_en), idx);
        compare_field("out_imm", 64'($signed(out_imm)), 64'($signed(e.imm)), idx);
        compare_field("out_status", 64'(out_status), 64'(e.status), idx);
    endtask

    // Fetch spends one credit per instruction sent
    task automatic drive_fetch();
        int cycles;
        cycles = 0;
        while (sent < exp_q.size() && cycles < max_cycles) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            if (queue_depth - sent + returned > 0 && ($random(seed) & 7) != 0) begin
                in_instr = exp_q[sent].instr;
                in_valid = 1'b1;
                sent++;
            end
            cycles++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (sent < exp_q.size()) begin
            $display("Timeout: fetch could not send all instructions");
            errors++;
        end
    endtask

    // Execute frees one slot per entry after a random gap
    task automatic return_credits();
        int cycles;
        int gap;
        cycles = 0;
        gap = 0;
        while (credits_given < exp_q.size() && cycles < max_cycles) begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (departures > credits_given) begin
                out_credit = 1'b1;
                credits_given++;
                gap = $random(seed) & 3;
                if (credits_given == stall_after) begin
                    gap = stall_cycles;
                end
            end
            cycles++;
        end
        @(posedge clk);
        #1;
        out_credit = 1'b0;
        if (credits_given < exp_q.size()) begin
            $display("Timeout: execute did not receive every entry");
            errors++;
        end
    endtask

    // Valid entries are sampled mid-cycle, before the edge they leave on
    task automatic monitor_outputs();
        int cycles;
        int tail;
        cycles = 0;
        tail = 0;
        while (tail < 20 && cycles < max_cycles) begin
            @(negedge clk);
            if (in_credit) begin
                returned++;
                assert (returned <= departures) else begin
                    $display("Credit returned to fetch with no entry leaving the queue");
                    errors++;
                end
            end
            if (out_valid) begin
                assert (departures < exp_q.size()) else begin
                    $display("Entry left the queue after all instructions were received");
                    errors++;
                end
                if (departures < exp_q.size()) begin
                    check_entry(exp_q[departures], departures);
                end
                departures++;
                assert (departures <= out_credit_init + credits_taken) else begin
                    $display("Entry left the queue without an output credit");
                    errors++;
                end
            end
            if (out_credit) begin
                credits_taken++;
            end
            if (departures >= exp_q.size() && returned == departures) begin
                tail++;
            end
            cycles++;
        end
        if (tail < 20) begin
            $display("Timeout: not all entries left the queue");
            errors++;
        end
    endtask

    initial begin
        int cycles;
        in_valid = 1'b0;
        in_instr = '0;
        out_credit = 1'b0;
        seed = 32'hc82e_4d3d;
        errors = 0;
        checks = 0;
        sent = 0;
        departures = 0;
        returned = 0;
        credits_given = 0;
        credits_taken = 0;
        load_stimulus();
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            errors++;
        end else begin
            @(negedge clk);
            compare_field("out_valid", 64'(out_valid), 64'd0, -1);
            compare_field("in_credit", 64'(in_credit), 64'd0, -1);
            fork
                drive_fetch();
                return_credits();
                monitor_outputs();
            join
        end
        assert (exp_q.size() > 0) else begin
            $display("No instructions were read from the stimulus file");
            errors++;
        end
        assert (departures == exp_q.size() && returned == departures) else begin
            $display("Entry or credit count mismatch: %0d sent, %0d left, %0d credits back",
                     exp_q.size(), departures, returned);
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* decode_stage.f */
hdl/riscv_isa_pkg.sv
hdl/decode_uarch_pkg.sv
hdl/instruction_decoder.sv
hdl/immediate_generator.sv
hdl/decode_issue_queue.sv
hdl/decode_stage.sv
verification/tb_clock_gen.sv
verification/decode_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module decode_stage_tb -f decode_stage.f \
    --Mdir obj_dir -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_stage_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0

/* verification/decode_stimulus.txt */
# instr format funct3 funct7 rs1 rs2 rd csr rs1_en rs2_en rd_en csr_en imm status, all hex
# format: 0 R, 1 I, 2 S, 3 B, 4 U, 5 J, 7 none; status 1 is illegal
002081B3 0 0 00 01 02 03 002 1 1 1 0 00000000 0
407302B3 0 0 20 06 07 05 407 1 1 1 0 00000000 0
00208033 0 0 00 01 02 00 002 1 1 0 0 00000000 0
003100D3 0 0 00 02 03 01 003 1 1 1 0 00000000 0
FFF00093 1 0 7F 00 1F 01 FFF 1 0 1 0 FFFFFFFF 0
7FF58513 1 0 3F 0B 1F 0A 7FF 1 0 1 0 000007FF 0
FF812203 1 2 7F 02 18 04 FF8 1 0 1 0 FFFFFFF8 0
00008067 1 0 00 01 00 00 000 1 0 0 0 00000000 0
FFE4849B 1 0 7F 09 1E 09 FFE 1 0 1 0 FFFFFFFE 0
FE512E23 2 2 7F 02 05 1C FE5 1 1 0 0 FFFFFFFC 0
06740223 2 0 03 08 07 04 067 1 1 0 0 00000064 0
FE2088E3 3 0 7F 01 02 11 FE2 1 1 0 0 FFFFFFF0 0
00419463 3 1 00 03 04 08 004 1 1 0 0 00000008 0
123452B7 4 5 09 08 03 05 123 0 0 1 0 12345000 0
FFFFF017 4 7 7F 1F 1F 00 FFF 0 0 0 0 FFFFF000 0
001000EF 5 0 00 00 01 01 001 0 0 1 0 00000800 0
FFDFF06F 5 7 7F 1F 1D 00 FFD 0 0 0 0 FFFFFFFC 0
300110F3 1 1 18 02 00 01 300 1 0 1 1 00000300 0
342021F3 1 2 1A 00 02 03 342 1 0 1 1 00000342 0
3042B073 1 3 18 05 04 00 304 1 0 0 1 00000304 0
3053D273 1 5 18 07 05 04 305 1 0 1 1 00000305 0
3400E373 1 6 1A 01 00 06 340 1 0 1 1 00000340 0
FFFFF3F3 1 7 7F 1F 1F 07 FFF 1 0 1 1 FFFFFFFF 0
00000073 1 0 00 00 00 00 000 1 0 0 0 00000000 0
00100073 1 0 00 00 01 00 001 1 0 0 0 00000001 0
0000007F 7 0 00 00 00 00 000 0 0 0 0 00000000 1
FFFFFFFF 7 7 7F 1F 1F 1F FFF 0 0 0 0 00000000 1
12345657 7 5 09 08 03 0C 123 0 0 0 0 00000000 1
00000000 7 0 00 00 00 00 000 0 0 0 0 00000000 1
